/* sim.f */
+incdir+hw
hw/fabric_pkg.sv
hw/mem_bus_if.sv
hw/addr_decoder.sv
hw/bus_arbiter.sv
hw/word_memory.sv
hw/femto_fabric.sv
verification/fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module fabric_tb -f sim.f -Mdir "$OBJ" -o fabric_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/fabric_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

/* verification/fabric_tb.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module fabric_tb;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_BUDGET = 400;
    localparam int TCM_IW      = $clog2(`TCM_WORDS);
    localparam int SRAM_IW     = $clog2(`SRAM_WORDS);

    logic                  clk = 1'b0;
    logic                  rstn = 1'b0;
    logic [`XLEN-1:0]      ibus_addr = '0;
    fabric_pkg::acc_size_e ibus_acc = fabric_pkg::ACC_WORD;
    logic                  ibus_req = 1'b0;
    logic [`BUS_WIDTH-1:0] ibus_rdata;
    logic                  ibus_resp;
    logic [`XLEN-1:0]      dbus_addr = '0;
    logic                  dbus_w_rb = 1'b0;
    fabric_pkg::acc_size_e dbus_acc = fabric_pkg::ACC_WORD;
    logic [`BUS_WIDTH-1:0] dbus_wdata = '0;
    logic                  dbus_req = 1'b0;
    logic [`BUS_WIDTH-1:0] dbus_rdata;
    logic                  dbus_resp;
    logic                  fault;

    logic [31:0]           lfsr = 32'hf5b281a9;
    logic [`BUS_WIDTH-1:0] tcm_ref [`TCM_WORDS];
    logic [`BUS_WIDTH-1:0] sram_ref [`SRAM_WORDS];
    logic [`XLEN-1:0]      written [$];

    int cyc = 0;
    int errs = 0;
    int test_errs = 0;
    int passed = 0;
    int failed = 0;
    // per bus: resp count, count at issue, due cycle (-1 when not exact), expected word
    int d_total = 0;
    int d_base = -1;
    int d_due = -1;
    logic d_chk = 1'b0;
    logic [`BUS_WIDTH-1:0] d_exp = '0;
    int i_total = 0;
    int i_base = -1;
    int i_due = -1;
    logic [`BUS_WIDTH-1:0] i_exp = '0;
    logic order_chk = 1'b0;
    logic fault_ref = 1'b0;

    femto_fabric DUT (
        .clk        (clk),
        .rstn       (rstn),
        .ibus_addr  (ibus_addr),
        .ibus_acc   (ibus_acc),
        .ibus_req   (ibus_req),
        .ibus_rdata (ibus_rdata),
        .ibus_resp  (ibus_resp),
        .dbus_addr  (dbus_addr),
        .dbus_w_rb  (dbus_w_rb),
        .dbus_acc   (dbus_acc),
        .dbus_wdata (dbus_wdata),
        .dbus_req   (dbus_req),
        .dbus_rdata (dbus_rdata),
        .dbus_resp  (dbus_resp),
        .fault      (fault)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic in_sram(input logic [31:0] addr);
        return (addr & `SRAM_SEL_MASK) == `SRAM_ADDR;
    endfunction

    function automatic logic is_mapped(input logic [31:0] addr);
        return ((addr & `TCM_SEL_MASK) == `TCM_ADDR) || in_sram(addr);
    endfunction

    function automatic int latency(input logic [31:0] addr);
        return in_sram(addr) ? 1 + `SRAM_WAIT : 1;
    endfunction

    function automatic logic [31:0] rand_addr(input logic to_sram);
        logic [31:0] off;
        off = rand_bits(14);
        return (to_sram ? `SRAM_ADDR : `TCM_ADDR) | {16'h0, off[13:0], 2'b00};
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [31:0] v;
        v = rand_bits(32);
        if (v[31:28] == 4'h1 || v[31:28] == 4'h2)
            v[31] = 1'b1;
        return v;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (in_sram(addr))
            return sram_ref[addr[SRAM_IW+1:2]];
        return tcm_ref[addr[TCM_IW+1:2]];
    endfunction

    // store data sits in the low bits of wdata
    task automatic model_write(input logic [31:0] addr, input fabric_pkg::acc_size_e acc,
                               input logic [31:0] data);
        logic [31:0] word;
        word = model_read(addr);
        case (acc)
            fabric_pkg::ACC_BYTE: word[{addr[1:0], 3'b000} +: 8] = data[7:0];
            fabric_pkg::ACC_HALF: word[{addr[1], 4'b0000} +: 16] = data[15:0];
            default: word = data;
        endcase
        if (in_sram(addr))
            sram_ref[addr[SRAM_IW+1:2]] = word;
        else
            tcm_ref[addr[TCM_IW+1:2]] = word;
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (dbus_resp)
            d_total <= d_total + 1;
        if (ibus_resp)
            i_total <= i_total + 1;
    end

    always @(posedge clk) begin
        if (!rstn)
            fault_ref <= 1'b0;
        else if (ibus_req || dbus_req)
            fault_ref <= (ibus_req && !is_mapped(ibus_addr)) ||
                         (dbus_req && !is_mapped(dbus_addr));
    end

    // checks sample at negedge, away from both input and register updates
    a_fault: assert property (@(negedge clk) disable iff (!rstn) fault == fault_ref)
        else begin
            errs++;
            $display("ERR %0t: fault is %b, expected %b", $time, fault, fault_ref);
        end
    a_d_once: assert property (@(negedge clk) disable iff (!rstn)
                               dbus_resp |-> d_total == d_base)
        else begin
            errs++;
            $display("ERR %0t: dbus resp with no open request", $time);
        end
    a_d_time: assert property (@(negedge clk) disable iff (!rstn)
                               (d_due >= 0 && cyc <= d_due && d_total == d_base)
                               |-> dbus_resp == (cyc == d_due))
        else begin
            errs++;
            $display("ERR %0t: dbus resp %b in cycle %0d, due %0d", $time, dbus_resp, cyc, d_due);
        end
    a_d_data: assert property (@(negedge clk) disable iff (!rstn)
                               (dbus_resp && d_chk) |-> dbus_rdata == d_exp)
        else begin
            errs++;
            $display("ERR %0t: dbus rdata %h, expected %h", $time, dbus_rdata, d_exp);
        end
    a_i_once: assert property (@(negedge clk) disable iff (!rstn)
                               ibus_resp |-> i_total == i_base)
        else begin
            errs++;
            $display("ERR %0t: ibus resp with no open request", $time);
        end
    a_i_time: assert property (@(negedge clk) disable iff (!rstn)
                               (i_due >= 0 && cyc <= i_due && i_total == i_base)
                               |-> ibus_resp == (cyc == i_due))
        else begin
            errs++;
            $display("ERR %0t: ibus resp %b in cycle %0d, due %0d", $time, ibus_resp, cyc, i_due);
        end
    a_i_data: assert property (@(negedge clk) disable iff (!rstn)
                               ibus_resp |-> ibus_rdata == i_exp)
        else begin
            errs++;
            $display("ERR %0t: ibus rdata %h, expected %h", $time, ibus_rdata, i_exp);
        end
    a_order: assert property (@(negedge clk) disable iff (!rstn)
                              (ibus_resp && order_chk) |-> d_total != d_base)
        else begin
            errs++;
            $display("ERR %0t: ibus resp came before the dbus resp", $time);
        end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic issue_dbus(input logic w, input fabric_pkg::acc_size_e acc,
                              input logic [31:0] addr, input logic [31:0] wdata);
        dbus_addr  = addr;
        dbus_w_rb  = w;
        dbus_acc   = acc;
        dbus_wdata = wdata;
        dbus_req   = 1'b1;
        if (is_mapped(addr)) begin
            d_base = d_total;
            d_due  = cyc + latency(addr);
            d_chk  = !w;
            d_exp  = model_read(addr);
            if (w)
                model_write(addr, acc, wdata);
        end
    endtask

    task automatic issue_ibus(input logic [31:0] addr, input logic exact);
        ibus_addr = addr;
        ibus_acc  = fabric_pkg::ACC_WORD;
        ibus_req  = 1'b1;
        if (is_mapped(addr)) begin
            i_base = i_total;
            i_due  = exact ? cyc + latency(addr) : -1;
            i_exp  = model_read(addr);
        end
    endtask

    task automatic dbus_access(input logic w, input fabric_pkg::acc_size_e acc,
                               input logic [31:0] addr, input logic [31:0] wdata);
        issue_dbus(w, acc, addr, wdata);
        next_cycle();
        dbus_req = 1'b0;
        while (d_total == d_base)
            next_cycle();
    endtask

    task automatic ibus_access(input logic [31:0] addr);
        issue_ibus(addr, 1'b1);
        next_cycle();
        ibus_req = 1'b0;
        while (i_total == i_base)
            next_cycle();
    endtask

    task automatic start_test();
        test_errs = errs;
    endtask

    task automatic end_test(input string name);
        if (errs == test_errs) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errs - test_errs);
        end
    endtask

    initial begin
        #(NUM_TESTS * TEST_BUDGET * 20);
        $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * TEST_BUDGET);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] a2;
        logic [31:0] r;
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        next_cycle();

        start_test();
        repeat (6) next_cycle();
        end_test("reset_idle");

        start_test();
        for (int n = 0; n < 8; n++) begin
            addr = rand_addr(n[0]);
            dbus_access(1'b1, fabric_pkg::ACC_WORD, addr, rand_bits(32));
            dbus_access(1'b0, fabric_pkg::ACC_WORD, addr, '0);
            written.push_back(addr);
        end
        end_test("word_write_read");

        // byte or half merge on top of a known word
        start_test();
        for (int n = 0; n < 8; n++) begin
            r = rand_bits(4);
            addr = rand_addr(r[0]);
            dbus_access(1'b1, fabric_pkg::ACC_WORD, addr, rand_bits(32));
            if (r[1])
                dbus_access(1'b1, fabric_pkg::ACC_HALF, {addr[31:2], r[2], 1'b0}, rand_bits(32));
            else
                dbus_access(1'b1, fabric_pkg::ACC_BYTE, {addr[31:2], r[3:2]}, rand_bits(32));
            dbus_access(1'b0, fabric_pkg::ACC_WORD, addr, '0);
            written.push_back(addr);
        end
        end_test("lane_merge");

        start_test();
        foreach (written[k])
            ibus_access(written[k]);
        end_test("ibus_read");

        start_test();
        order_chk = 1'b1;
        for (int n = 0; n < 4; n++) begin
            addr = rand_addr(n[0]);
            a2 = rand_addr(n[0]);
            dbus_access(1'b1, fabric_pkg::ACC_WORD, addr, rand_bits(32));
            dbus_access(1'b1, fabric_pkg::ACC_WORD, a2, rand_bits(32));
            issue_dbus(1'b0, fabric_pkg::ACC_WORD, addr, '0);
            issue_ibus(a2, 1'b0);
            next_cycle();
            dbus_req = 1'b0;
            ibus_req = 1'b0;
            while (d_total == d_base || i_total == i_base)
                next_cycle();
        end
        order_chk = 1'b0;
        end_test("contention");

        // dbus fault first, then ibus
        start_test();
        for (int n = 0; n < 2; n++) begin
            addr = unmapped_addr();
            if (n == 0)
                issue_dbus(1'b0, fabric_pkg::ACC_WORD, addr, '0);
            else
                issue_ibus(addr, 1'b1);
            next_cycle();
            dbus_req = 1'b0;
            ibus_req = 1'b0;
            repeat (2 + `SRAM_WAIT) next_cycle();
            if (n == 0)
                dbus_access(1'b0, fabric_pkg::ACC_WORD, written[n], '0);
            else
                ibus_access(written[n]);
        end
        end_test("unmapped_fault");

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errs);
        if (failed == 0 && errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end
endmodule

/* hw/femto_fabric.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module femto_fabric (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic [`XLEN-1:0]      ibus_addr,
    input  fabric_pkg::acc_size_e ibus_acc,
    input  logic                  ibus_req,
    output logic [`BUS_WIDTH-1:0] ibus_rdata,
    output logic                  ibus_resp,

    input  logic [`XLEN-1:0]      dbus_addr,
    input  logic                  dbus_w_rb,
    input  fabric_pkg::acc_size_e dbus_acc,
    input  logic [`BUS_WIDTH-1:0] dbus_wdata,
    input  logic                  dbus_req,
    output logic [`BUS_WIDTH-1:0] dbus_rdata,
    output logic                  dbus_resp,

    output logic                  fault
);
    logic ibus_unmapped;
    logic dbus_unmapped;

    mem_bus_if ibus ();
    mem_bus_if dbus ();
    mem_bus_if ibus_tcm ();
    mem_bus_if ibus_sram ();
    mem_bus_if dbus_tcm ();
    mem_bus_if dbus_sram ();
    mem_bus_if tcm_mem ();
    mem_bus_if sram_mem ();

    // instruction bus only reads
    assign ibus.addr  = ibus_addr;
    assign ibus.w_rb  = 1'b0;
    assign ibus.acc   = ibus_acc;
    assign ibus.wdata = '0;
    assign ibus.req   = ibus_req;

    assign dbus.addr  = dbus_addr;
    assign dbus.w_rb  = dbus_w_rb;
    assign dbus.acc   = dbus_acc;
    assign dbus.wdata = dbus_wdata;
    assign dbus.req   = dbus_req;

    addr_decoder u_ibus_dec (.clk(clk), .rstn(rstn), .up(ibus), .tcm(ibus_tcm),
                             .sram(ibus_sram), .unmapped(ibus_unmapped));
    addr_decoder u_dbus_dec (.clk(clk), .rstn(rstn), .up(dbus), .tcm(dbus_tcm),
                             .sram(dbus_sram), .unmapped(dbus_unmapped));

    bus_arbiter u_tcm_arb (.clk(clk), .rstn(rstn), .ibus(ibus_tcm), .dbus(dbus_tcm),
                           .mem(tcm_mem));
    bus_arbiter u_sram_arb (.clk(clk), .rstn(rstn), .ibus(ibus_sram), .dbus(dbus_sram),
                            .mem(sram_mem));

    word_memory #(
        .WORDS       (`TCM_WORDS),
        .WAIT_CYCLES (0)
    ) u_tcm (
        .clk  (clk),
        .rstn (rstn),
        .bus  (tcm_mem)
    );

    word_memory #(
        .WORDS       (`SRAM_WORDS),
        .WAIT_CYCLES (`SRAM_WAIT)
    ) u_sram (
        .clk  (clk),
        .rstn (rstn),
        .bus  (sram_mem)
    );

    // sampled on every request, cleared by a mapped one
    always_ff @(posedge clk) begin
        if (!rstn)
            fault <= 1'b0;
        else if (ibus_req | dbus_req)
            fault <= ibus_unmapped | dbus_unmapped;
    end

    assign ibus_resp  = ibus.resp & ~fault;
    assign dbus_resp  = dbus.resp & ~fault;
    assign ibus_rdata = ibus.rdata;
    assign dbus_rdata = dbus.rdata;
endmodule

/* hw/word_memory.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module word_memory #(
    parameter int WORDS       = 256,
    parameter int WAIT_CYCLES = 0
) (
    input  logic     clk,
    input  logic     rstn,
    mem_bus_if.target bus
);
    localparam int IDX_W = $clog2(WORDS);
    localparam int CNT_W = $clog2(WAIT_CYCLES + 2);
    localparam int LANES = `BUS_WIDTH / 8;

    logic [`BUS_WIDTH-1:0] mem [WORDS];

    logic [`XLEN-1:0]      addr_q;
    logic                  w_rb_q;
    fabric_pkg::acc_size_e acc_q;
    logic [`BUS_WIDTH-1:0] wdata_q;

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic             done;
    logic [IDX_W-1:0] idx;
    logic [LANES-1:0] be;
    logic [`BUS_WIDTH-1:0] wdata_lane;

    always_ff @(posedge clk) begin
        if (bus.req) begin
            addr_q  <= bus.addr;
            w_rb_q  <= bus.w_rb;
            acc_q   <= bus.acc;
            wdata_q <= bus.wdata;
        end
    end

    // a new req may land on the done cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (bus.req) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(WAIT_CYCLES);
        end else if (done) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - CNT_W'(1);
        end
    end

    assign done = busy_q && (cnt_q == '0);
    assign idx  = addr_q[IDX_W+1:2];

    // store data in the low bits is copied onto every lane
    always_comb begin
        case (acc_q)
            fabric_pkg::ACC_BYTE: begin
                be         = {{(LANES-1){1'b0}}, 1'b1} << addr_q[1:0];
                wdata_lane = {LANES{wdata_q[7:0]}};
            end
            fabric_pkg::ACC_HALF: begin
                be         = addr_q[1] ? {2'b11, {(LANES-2){1'b0}}} : {{(LANES-2){1'b0}}, 2'b11};
                wdata_lane = {(LANES/2){wdata_q[15:0]}};
            end
            default: begin
                be         = '1;
                wdata_lane = wdata_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (done && w_rb_q) begin
            for (int i = 0; i < LANES; i++) begin
                if (be[i])
                    mem[idx][i*8 +: 8] <= wdata_lane[i*8 +: 8];
            end
        end
    end

    assign bus.resp  = done;
    assign bus.rdata = mem[idx];
endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module bus_arbiter (
    input  logic       clk,
    input  logic       rstn,
    mem_bus_if.target    ibus,
    mem_bus_if.target    dbus,
    mem_bus_if.initiator mem
);
    logic [`XLEN-1:0]      ibus_addr_q;
    logic                  ibus_w_rb_q;
    fabric_pkg::acc_size_e ibus_acc_q;
    logic [`BUS_WIDTH-1:0] ibus_wdata_q;
    logic [`XLEN-1:0]      dbus_addr_q;
    logic                  dbus_w_rb_q;
    fabric_pkg::acc_size_e dbus_acc_q;
    logic [`BUS_WIDTH-1:0] dbus_wdata_q;

    logic ibus_busy_q;
    logic dbus_busy_q;
    logic ibus_pend;
    logic dbus_pend;

    fabric_pkg::arb_state_e state_q;
    fabric_pkg::arb_state_e state_d;

    // hold request fields for a deferred grant
    always_ff @(posedge clk) begin
        if (ibus.req) begin
            ibus_addr_q  <= ibus.addr;
            ibus_w_rb_q  <= ibus.w_rb;
            ibus_acc_q   <= ibus.acc;
            ibus_wdata_q <= ibus.wdata;
        end
        if (dbus.req) begin
            dbus_addr_q  <= dbus.addr;
            dbus_w_rb_q  <= dbus.w_rb;
            dbus_acc_q   <= dbus.acc;
            dbus_wdata_q <= dbus.wdata;
        end
    end

    // access ongoing until that bus sees its resp
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ibus_busy_q <= 1'b0;
            dbus_busy_q <= 1'b0;
            state_q     <= fabric_pkg::ARB_IDLE;
        end else begin
            if (ibus.req | ibus.resp)
                ibus_busy_q <= ibus.req;
            if (dbus.req | dbus.resp)
                dbus_busy_q <= dbus.req;
            state_q <= state_d;
        end
    end

    assign ibus_pend = ibus.req | ibus_busy_q;
    assign dbus_pend = dbus.req | dbus_busy_q;

    always_comb begin
        state_d = state_q;
        mem.req = 1'b0;
        case (state_q)
            fabric_pkg::ARB_IBUS: begin
                if (mem.resp) begin
                    mem.req = dbus_pend | ibus.req;
                    if (dbus_pend)
                        state_d = fabric_pkg::ARB_DBUS;
                    else if (!ibus.req)
                        state_d = fabric_pkg::ARB_IDLE;
                end
            end
            fabric_pkg::ARB_DBUS: begin
                if (mem.resp) begin
                    mem.req = ibus_pend | dbus.req;
                    if (ibus_pend)
                        state_d = fabric_pkg::ARB_IBUS;
                    else if (!dbus.req)
                        state_d = fabric_pkg::ARB_IDLE;
                end
            end
            default: begin
                // data bus wins a tie
                mem.req = ibus.req | dbus.req;
                if (dbus.req)
                    state_d = fabric_pkg::ARB_DBUS;
                else if (ibus.req)
                    state_d = fabric_pkg::ARB_IBUS;
            end
        endcase
    end

    // live fields in a req cycle, captured ones otherwise
    always_comb begin
        if (state_d == fabric_pkg::ARB_IBUS) begin
            mem.addr  = ibus.req ? ibus.addr  : ibus_addr_q;
            mem.w_rb  = ibus.req ? ibus.w_rb  : ibus_w_rb_q;
            mem.wdata = ibus.req ? ibus.wdata : ibus_wdata_q;
            if (ibus.req)
                mem.acc = ibus.acc;
            else
                mem.acc = ibus_acc_q;
        end else begin
            mem.addr  = dbus.req ? dbus.addr  : dbus_addr_q;
            mem.w_rb  = dbus.req ? dbus.w_rb  : dbus_w_rb_q;
            mem.wdata = dbus.req ? dbus.wdata : dbus_wdata_q;
            if (dbus.req)
                mem.acc = dbus.acc;
            else
                mem.acc = dbus_acc_q;
        end
    end

    assign ibus.resp  = (state_q == fabric_pkg::ARB_IBUS) & mem.resp;
    assign dbus.resp  = (state_q == fabric_pkg::ARB_DBUS) & mem.resp;
    assign ibus.rdata = (state_q == fabric_pkg::ARB_IBUS) ? mem.rdata : '0;
    assign dbus.rdata = (state_q == fabric_pkg::ARB_DBUS) ? mem.rdata : '0;
endmodule

/* hw/addr_decoder.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module addr_decoder (
    input  logic       clk,
    input  logic       rstn,
    mem_bus_if.target    up,
    mem_bus_if.initiator tcm,
    mem_bus_if.initiator sram,
    output logic       unmapped
);
    logic tcm_hit;
    logic sram_hit;
    logic tcm_sel_q;
    logic sram_sel_q;

    assign tcm_hit  = (up.addr & `TCM_SEL_MASK) == `TCM_ADDR;
    assign sram_hit = (up.addr & `SRAM_SEL_MASK) == `SRAM_ADDR;

    // request fields fan out, only req is steered
    assign tcm.addr  = up.addr;
    assign tcm.w_rb  = up.w_rb;
    assign tcm.acc   = up.acc;
    assign tcm.wdata = up.wdata;
    assign tcm.req   = up.req & tcm_hit;

    assign sram.addr  = up.addr;
    assign sram.w_rb  = up.w_rb;
    assign sram.acc   = up.acc;
    assign sram.wdata = up.wdata;
    assign sram.req   = up.req & sram_hit;

    assign unmapped = up.req & ~tcm_hit & ~sram_hit;

    // remember the target until its response comes back
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcm_sel_q  <= 1'b0;
            sram_sel_q <= 1'b0;
        end else if (up.req) begin
            tcm_sel_q  <= tcm_hit;
            sram_sel_q <= sram_hit;
        end
    end

    always_comb begin
        up.resp  = 1'b0;
        up.rdata = '0;
        if (tcm_sel_q) begin
            up.resp  = tcm.resp;
            up.rdata = tcm.rdata;
        end else if (sram_sel_q) begin
            up.resp  = sram.resp;
            up.rdata = sram.rdata;
        end
    end
endmodule

/* hw/mem_bus_if.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

interface mem_bus_if;
    logic [`XLEN-1:0]      addr;
    logic                  w_rb;
    fabric_pkg::acc_size_e acc;
    logic [`BUS_WIDTH-1:0] wdata;
    logic [`BUS_WIDTH-1:0] rdata;
    logic                  req;
    logic                  resp;

    modport initiator (
        output addr, w_rb, acc, wdata, req,
        input  rdata, resp
    );

    modport target (
        input  addr, w_rb, acc, wdata, req,
        output rdata, resp
    );
endinterface

/* hw/fabric_pkg.sv */
package fabric_pkg;

    // access size carried on every bus
    typedef enum logic [1:0] {
        ACC_BYTE = 2'd0,
        ACC_HALF = 2'd1,
        ACC_WORD = 2'd2
    } acc_size_e;

    // which initiator owns a shared memory
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_IBUS = 2'd1,
        ARB_DBUS = 2'd2
    } arb_state_e;

endpackage

/* hw/fabric_consts.svh */
`ifndef FABRIC_CONSTS_SVH
`define FABRIC_CONSTS_SVH

// bus widths
`define XLEN            32
`define BUS_WIDTH       32

// memory map, regions picked on the top nibble
`define TCM_ADDR        32'h1000_0000
`define TCM_SEL_MASK    32'hf000_0000
`define SRAM_ADDR       32'h2000_0000
`define SRAM_SEL_MASK   32'hf000_0000

// region sizes in words
`define TCM_WORDS       256
`define SRAM_WORDS      512

`define SRAM_WAIT       2

`endif
